//--- hdl/coherence_pkg.sv
package coherence_pkg;

    // number of private L1 data caches on the snooping bus
    localparam int CPUS = 4;
    // width of a cache index
    localparam int CPU_ID_W = $clog2(CPUS);

    // a block is one 64-bit long word, so the low three address bits drop out
    localparam int BLOCK_MASK_BITS = 3;

    // cycles from a held L2 enable to L2_ACCESS
    localparam int L2_LATENCY = 3;
    // blocks held by the L2 model
    localparam int L2_DEPTH = 64;
    localparam int L2_IDX_W = $clog2(L2_DEPTH);
    // latency counter has to reach L2_LATENCY itself
    localparam int L2_CNT_W = $clog2(L2_LATENCY + 1);

    typedef logic [31:0] word_t;
    typedef logic [63:0] long_word_t;

    // bus FSM states
    typedef enum logic [3:0] {
        IDLE, SNOOP, SNOOP_INV,
        RMEM, RMEM_INV, RMEM_FIN, RMEM_EXCL_FIN,
        TRANSFER, TRANSFER_FIN, TRANSFER_INV, TRANSFER_INV_FIN,
        WMEM_TRANSFER, WMEM, WMEM_FIN,
        UPDATE, UPDATE_FIN
    } bus_state_t;

    // L2 access phases as seen by the bus controller
    typedef enum logic [1:0] {
        L2_FREE, L2_BUSY, L2_ACCESS
    } l2_state_t;

    // request kinds decoded from the L1 levels
    typedef enum logic [2:0] {
        REQ_NONE, REQ_RD, REQ_RDX, REQ_UPD, REQ_WB
    } req_kind_t;

    // block-aligned form of a byte address
    function automatic word_t block_align(input word_t addr);
        return addr & ~word_t'((1 << BLOCK_MASK_BITS) - 1);
    endfunction

endpackage

//--- hdl/bus_request_arbiter.sv
`timescale 1ns/1ps

module bus_request_arbiter
    import coherence_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic [CPUS-1:0]     cctrans,
    input  logic [CPUS-1:0]     dREN,
    input  logic [CPUS-1:0]     dWEN,
    input  logic [CPUS-1:0]     ccwrite,
    input  logic                bus_idle,
    output logic                req_valid,
    output logic [CPU_ID_W-1:0] requester,
    output req_kind_t           req_kind
);

    logic [CPU_ID_W-1:0] winner;
    req_kind_t           winner_kind;

    // fixed priority, highest index with cctrans wins
    always_comb begin
        winner = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (cctrans[i]) winner = CPU_ID_W'(i);
        end
    end

    // classify the winning cache, writeback first
    always_comb begin
        if (dWEN[winner]) winner_kind = REQ_WB;
        else if (dREN[winner] && ccwrite[winner]) winner_kind = REQ_RDX;
        else if (dREN[winner]) winner_kind = REQ_RD;
        else if (ccwrite[winner]) winner_kind = REQ_UPD;
        else winner_kind = REQ_NONE;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_valid <= 1'b0;
            requester <= '0;
            req_kind  <= REQ_NONE;
        end else if (bus_idle) begin
            req_valid <= |cctrans;
            requester <= winner;
            req_kind  <= winner_kind;
        end else begin
            // requester and kind stay put for the whole transaction
            // valid drops so a finished request is never replayed
            req_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl
    import coherence_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    input  logic [CPU_ID_W-1:0]   requester,
    input  req_kind_t             req_kind,
    output logic                  bus_idle,
    input  word_t      [CPUS-1:0] daddr,
    input  long_word_t [CPUS-1:0] dstore,
    input  logic       [CPUS-1:0] ccsnoophit,
    input  logic       [CPUS-1:0] ccIsPresent,
    input  logic       [CPUS-1:0] ccdirty,
    output logic       [CPUS-1:0] dwait,
    output logic       [CPUS-1:0] ccwait,
    output logic       [CPUS-1:0] ccinv,
    output logic       [CPUS-1:0] ccexclusive,
    output word_t      [CPUS-1:0] ccsnoopaddr,
    output long_word_t [CPUS-1:0] dload,
    output logic                  l2REN,
    output logic                  l2WEN,
    output word_t                 l2addr,
    output long_word_t            l2store,
    input  long_word_t            l2load,
    input  l2_state_t             l2state
);

    bus_state_t          state, nstate;
    logic [CPU_ID_W-1:0] supplier, nsupplier;
    logic                supplier_dirty, nsupplier_dirty;
    logic                excl_grant, nexcl_grant;
    logic                snoop_phase, nsnoop_phase;
    logic [CPU_ID_W-1:0] hit_id;
    logic                hit_dirty, hit_any;
    logic [CPUS-1:0]     others, nccinv;
    word_t [CPUS-1:0]    nccsnoopaddr;
    word_t               req_blk, nl2addr;
    long_word_t          nl2store, ndload;
    logic                dload_en;

    // every cache except the requester
    assign others = ~(CPUS'(1) << requester);
    assign req_blk = block_align(daddr[requester]);
    // new request only taken once the arbiter has nothing pending
    assign bus_idle = (state == IDLE) && !req_valid;

    // control state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            supplier       <= '0;
            supplier_dirty <= 1'b0;
            excl_grant     <= 1'b0;
            snoop_phase    <= 1'b0;
            ccinv          <= '0;
        end else begin
            state          <= nstate;
            supplier       <= nsupplier;
            supplier_dirty <= nsupplier_dirty;
            excl_grant     <= nexcl_grant;
            snoop_phase    <= nsnoop_phase;
            ccinv          <= nccinv;
        end
    end

    // payload registers
    always_ff @(posedge CLK) begin
        ccsnoopaddr <= nccsnoopaddr;
        l2addr      <= nl2addr;
        l2store     <= nl2store;
        if (dload_en) dload[requester] <= ndload;
    end

    // pick the snoop supplier among the other caches
    // M/E guarantee at most one hit, so the last one found is the only one
    always_comb begin
        hit_id    = supplier;
        hit_dirty = 1'b0;
        hit_any   = 1'b0;
        for (int i = 0; i < CPUS; i++) begin
            if (ccsnoophit[i] && others[i]) begin
                hit_id    = CPU_ID_W'(i);
                hit_dirty = ccdirty[i];
                hit_any   = 1'b1;
            end
        end
    end

    // next state, supplier capture and invalidate pulse
    always_comb begin
        nstate          = state;
        nsupplier       = supplier;
        nsupplier_dirty = supplier_dirty;
        nexcl_grant     = excl_grant;
        nsnoop_phase    = 1'b0;
        nccinv          = '0;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    case (req_kind)
                        REQ_WB:  nstate = WMEM;
                        REQ_RDX: nstate = SNOOP_INV;
                        REQ_RD:  nstate = SNOOP;
                        REQ_UPD: nstate = UPDATE;
                        default: nstate = IDLE;
                    endcase
                end
            end
            SNOOP, SNOOP_INV: begin
                // first cycle gives the caches time to look up ccsnoopaddr
                nsnoop_phase = !snoop_phase;
                if (snoop_phase) begin
                    nsupplier       = hit_id;
                    nsupplier_dirty = hit_dirty;
                    // E only if nobody else holds the block
                    nexcl_grant     = !(|(ccIsPresent & others));
                    if (state == SNOOP) begin
                        nstate = hit_any ? TRANSFER : RMEM;
                    end else begin
                        nstate = hit_any ? TRANSFER_INV : RMEM_INV;
                        nccinv = others;
                    end
                end
            end
            RMEM: begin
                if (l2state == L2_ACCESS) nstate = excl_grant ? RMEM_EXCL_FIN : RMEM_FIN;
            end
            RMEM_INV: begin
                if (l2state == L2_ACCESS) nstate = RMEM_EXCL_FIN;
            end
            TRANSFER:     nstate = TRANSFER_FIN;
            // M -> S supplier leaves L2 stale, write it back
            TRANSFER_FIN: nstate = supplier_dirty ? WMEM_TRANSFER : IDLE;
            TRANSFER_INV: nstate = TRANSFER_INV_FIN;
            WMEM_TRANSFER, WMEM: nstate = WMEM_FIN;
            WMEM_FIN: begin
                if (l2state == L2_ACCESS) nstate = IDLE;
            end
            UPDATE: begin
                nstate = UPDATE_FIN;
                nccinv = others;
            end
            default: nstate = IDLE;
        endcase
    end

    // snoop address, L2 address/data and requester data
    always_comb begin
        nccsnoopaddr = ccsnoopaddr;
        nl2addr      = l2addr;
        nl2store     = l2store;
        ndload       = l2load;
        dload_en     = 1'b0;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    nl2addr = req_blk;
                    if (req_kind == REQ_WB) begin
                        nl2store = dstore[requester];
                    end else begin
                        for (int i = 0; i < CPUS; i++) begin
                            if (others[i]) nccsnoopaddr[i] = req_blk;
                        end
                    end
                end
            end
            RMEM, RMEM_INV: dload_en = (l2state == L2_ACCESS);
            TRANSFER, TRANSFER_INV: begin
                dload_en = 1'b1;
                ndload   = dstore[supplier];
            end
            // dload still holds the supplier block
            WMEM_TRANSFER: nl2store = dload[requester];
            default: ;
        endcase
    end

    // unregistered bus outputs
    always_comb begin
        dwait       = '1;
        ccwait      = '0;
        ccexclusive = '0;
        l2REN       = 1'b0;
        l2WEN       = 1'b0;
        case (state)
            SNOOP, SNOOP_INV, TRANSFER, TRANSFER_INV, UPDATE: ccwait = others;
            RMEM: l2REN = 1'b1;
            RMEM_INV: begin
                l2REN  = 1'b1;
                ccwait = others;
            end
            RMEM_FIN, TRANSFER_FIN: dwait[requester] = 1'b0;
            // only reached with no other holder or on ownership
            RMEM_EXCL_FIN, TRANSFER_INV_FIN: begin
                dwait[requester]       = 1'b0;
                ccexclusive[requester] = 1'b1;
            end
            // eviction data is already latched, requester can go
            WMEM: dwait[requester] = 1'b0;
            WMEM_FIN: l2WEN = 1'b1;
            UPDATE_FIN: begin
                ccwait                 = others;
                dwait[requester]       = 1'b0;
                ccexclusive[requester] = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/l2_memory.sv
`timescale 1ns/1ps

module l2_memory
    import coherence_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       l2REN,
    input  logic       l2WEN,
    input  word_t      l2addr,
    input  long_word_t l2store,
    output long_word_t l2load,
    output l2_state_t  l2state
);

    long_word_t          mem [L2_DEPTH];
    logic [L2_IDX_W-1:0] idx;
    logic [L2_CNT_W-1:0] cnt;
    logic                enable;

    // block address modulo depth
    assign idx    = l2addr[BLOCK_MASK_BITS +: L2_IDX_W];
    assign enable = l2REN | l2WEN;

    // FREE -> BUSY on enable, ACCESS for one cycle after L2_LATENCY cycles
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            l2state <= L2_FREE;
            cnt     <= '0;
            for (int i = 0; i < L2_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (l2state)
                L2_FREE: begin
                    if (enable) begin
                        cnt     <= L2_CNT_W'(1);
                        l2state <= (L2_LATENCY == 1) ? L2_ACCESS : L2_BUSY;
                    end
                end
                L2_BUSY: begin
                    // enable dropped early, access abandoned
                    if (!enable) begin
                        l2state <= L2_FREE;
                    end else begin
                        cnt <= cnt + 1'b1;
                        if (cnt + 1'b1 == L2_CNT_W'(L2_LATENCY)) l2state <= L2_ACCESS;
                    end
                end
                L2_ACCESS: begin
                    if (l2WEN) mem[idx] <= l2store;
                    l2state <= L2_FREE;
                end
                default: l2state <= L2_FREE;
            endcase
        end
    end

    // read data only shows up in the access cycle
    assign l2load = (l2state == L2_ACCESS && l2REN) ? mem[idx] : '0;

endmodule

//--- hdl/coherence_bus_top.sv
`timescale 1ns/1ps

module coherence_bus_top
    import coherence_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    // L1 request levels
    input  logic       [CPUS-1:0] cctrans,
    input  logic       [CPUS-1:0] dREN,
    input  logic       [CPUS-1:0] dWEN,
    input  logic       [CPUS-1:0] ccwrite,
    input  word_t      [CPUS-1:0] daddr,
    input  long_word_t [CPUS-1:0] dstore,
    // snoop replies
    input  logic       [CPUS-1:0] ccsnoophit,
    input  logic       [CPUS-1:0] ccIsPresent,
    input  logic       [CPUS-1:0] ccdirty,
    // back to the L1s
    output logic       [CPUS-1:0] dwait,
    output long_word_t [CPUS-1:0] dload,
    output logic       [CPUS-1:0] ccwait,
    output logic       [CPUS-1:0] ccinv,
    output word_t      [CPUS-1:0] ccsnoopaddr,
    output logic       [CPUS-1:0] ccexclusive
);

    logic                req_valid;
    logic [CPU_ID_W-1:0] requester;
    req_kind_t           req_kind;
    logic                bus_idle;
    logic                l2REN, l2WEN;
    word_t               l2addr;
    long_word_t          l2store, l2load;
    l2_state_t           l2state;

    // decode, picks and classifies the requester
    bus_request_arbiter u_arb (
        .CLK       (CLK),
        .nRST      (nRST),
        .cctrans   (cctrans),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .ccwrite   (ccwrite),
        .bus_idle  (bus_idle),
        .req_valid (req_valid),
        .requester (requester),
        .req_kind  (req_kind)
    );

    // execute, MESI bus FSM
    bus_ctrl u_bus (
        .CLK         (CLK),
        .nRST        (nRST),
        .req_valid   (req_valid),
        .requester   (requester),
        .req_kind    (req_kind),
        .bus_idle    (bus_idle),
        .daddr       (daddr),
        .dstore      (dstore),
        .ccsnoophit  (ccsnoophit),
        .ccIsPresent (ccIsPresent),
        .ccdirty     (ccdirty),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccexclusive (ccexclusive),
        .ccsnoopaddr (ccsnoopaddr),
        .dload       (dload),
        .l2REN       (l2REN),
        .l2WEN       (l2WEN),
        .l2addr      (l2addr),
        .l2store     (l2store),
        .l2load      (l2load),
        .l2state     (l2state)
    );

    // shared L2 backing store
    l2_memory u_l2 (
        .CLK     (CLK),
        .nRST    (nRST),
        .l2REN   (l2REN),
        .l2WEN   (l2WEN),
        .l2addr  (l2addr),
        .l2store (l2store),
        .l2load  (l2load),
        .l2state (l2state)
    );

endmodule

//--- test/coherence_bus_tb.sv
`timescale 1ns/1ps

module coherence_bus_tb
    import coherence_pkg::*;
();

    localparam int NBLK = 4;
    localparam int N_DIRECTED = 7;
    localparam int N_RANDOM = 24;
    // reset cycles plus a generous bound per bus transaction
    localparam int WATCHDOG_CYCLES = 2 + 200 * (N_DIRECTED + N_RANDOM);

    typedef enum logic [1:0] {ST_I, ST_S, ST_E, ST_M} mesi_t;

    logic                  CLK, nRST;
    logic       [CPUS-1:0] cctrans, dREN, dWEN, ccwrite;
    logic       [CPUS-1:0] ccsnoophit, ccIsPresent, ccdirty;
    word_t      [CPUS-1:0] daddr, ccsnoopaddr;
    long_word_t [CPUS-1:0] dstore, dload;
    logic       [CPUS-1:0] dwait, ccwait, ccinv, ccexclusive;

    // L1 models and reference L2, one entry per test block
    mesi_t      mesi [CPUS][NBLK];
    long_word_t cdata [CPUS][NBLK];
    long_word_t ref_l2 [NBLK];
    word_t      addr_tab [NBLK];

    integer          seed;
    int              errors, checks;
    logic            active;
    int              cur_req;
    req_kind_t       cur_kind;
    word_t           cur_addr;
    long_word_t      exp_data;
    logic            exp_excl, exp_l2, exp_wr;
    logic [CPUS-1:0] exp_inv, inv_seen, wait_seen;
    logic            l2_seen, wr_seen;
    event            txn_done;

    coherence_bus_top uut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic check(input long_word_t got, input long_word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // last other cache holding the block, -1 when nobody has it
    function automatic int find_holder(input int req, input int blk);
        int h;
        h = -1;
        for (int i = 0; i < CPUS; i++) begin
            if (i != req && mesi[i][blk] != ST_I) h = i;
        end
        return h;
    endfunction

    // expected dload, ccexclusive and L2 use from the MESI rules
    function automatic void expect_txn(input int req, input req_kind_t kind, input int blk,
            output long_word_t data, output logic excl, output logic l2_used);
        int h;
        h = find_holder(req, blk);
        data = '0;
        excl = 1'b0;
        l2_used = 1'b0;
        if (kind == REQ_RD || kind == REQ_RDX) begin
            // a holder supplies the block, otherwise L2 does
            data = (h >= 0) ? cdata[h][blk] : ref_l2[blk];
            l2_used = (h < 0);
            excl = (kind == REQ_RDX) || (h < 0);
        end else if (kind == REQ_UPD) begin
            excl = 1'b1;
        end
    endfunction

    task automatic update_model(input int req, input req_kind_t kind, input int blk);
        int h;
        h = find_holder(req, blk);
        case (kind)
            REQ_RD: begin
                if (h >= 0) begin
                    // a dirty supplier is written back on the way
                    if (mesi[h][blk] == ST_M) ref_l2[blk] = cdata[h][blk];
                    for (int i = 0; i < CPUS; i++) begin
                        if (i != req && mesi[i][blk] != ST_I) mesi[i][blk] = ST_S;
                    end
                    mesi[req][blk] = ST_S;
                    cdata[req][blk] = cdata[h][blk];
                end else begin
                    mesi[req][blk] = ST_E;
                    cdata[req][blk] = ref_l2[blk];
                end
            end
            REQ_RDX, REQ_UPD: begin
                for (int i = 0; i < CPUS; i++) begin
                    if (i != req) mesi[i][blk] = ST_I;
                end
                mesi[req][blk] = ST_M;
                // the requester stores right after gaining ownership
                cdata[req][blk] = {$random(seed), $random(seed)};
            end
            REQ_WB: begin
                ref_l2[blk] = cdata[req][blk];
                mesi[req][blk] = ST_I;
            end
            default: ;
        endcase
    endtask

    task automatic run_txn(input int req, input req_kind_t kind, input int blk);
        int h;
        while (!uut.bus_idle) @(negedge CLK);
        expect_txn(req, kind, blk, exp_data, exp_excl, exp_l2);
        // invalidating kinds hit every cache but the requester
        for (int i = 0; i < CPUS; i++) begin
            exp_inv[i] = (i != req) && (kind == REQ_RDX || kind == REQ_UPD);
        end
        // L2 is written on an eviction or when an M supplier shares its block
        h = find_holder(req, blk);
        exp_wr = (kind == REQ_WB);
        if (kind == REQ_RD && h >= 0) exp_wr = (mesi[h][blk] == ST_M);
        cur_req = req;
        cur_kind = kind;
        cur_addr = addr_tab[blk];
        @(posedge CLK);
        cctrans[req] <= 1'b1;
        dREN[req] <= (kind == REQ_RD || kind == REQ_RDX);
        dWEN[req] <= (kind == REQ_WB);
        ccwrite[req] <= (kind == REQ_RDX || kind == REQ_UPD);
        daddr[req] <= addr_tab[blk];
        // other caches present their copy in case they supply it
        for (int i = 0; i < CPUS; i++) begin
            if (i != req) dstore[i] <= cdata[i][blk];
            else dstore[i] <= (kind == REQ_WB) ? cdata[req][blk] : '0;
        end
        wr_seen = 1'b0;
        active = 1'b1;
        @(txn_done);
        active = 1'b0;
        // levels drop on the edge that ends the dwait low cycle
        @(posedge CLK);
        cctrans <= '0;
        dREN <= '0;
        dWEN <= '0;
        ccwrite <= '0;
        update_model(req, kind, blk);
        @(negedge CLK);
        // writebacks trail the release, so wait for the bus to settle
        while (!uut.bus_idle) @(negedge CLK);
        check(64'(wr_seen), 64'(exp_wr), "L2 write");
    endtask

    // L1 snoop side, answers one cycle after ccsnoopaddr moves
    initial begin
        word_t [CPUS-1:0] snap;
        logic             hit, dirty;
        ccsnoophit = '0;
        ccIsPresent = '0;
        ccdirty = '0;
        forever begin
            @(negedge CLK);
            snap = ccsnoopaddr;
            @(posedge CLK);
            for (int i = 0; i < CPUS; i++) begin
                hit = 1'b0;
                dirty = 1'b0;
                for (int b = 0; b < NBLK; b++) begin
                    if (snap[i] == addr_tab[b] && mesi[i][b] != ST_I) begin
                        hit = 1'b1;
                        dirty = (mesi[i][b] == ST_M);
                    end
                end
                ccsnoophit[i] <= hit;
                ccIsPresent[i] <= hit;
                ccdirty[i] <= dirty;
            end
        end
    end

    // compare on the falling requester dwait
    initial begin
        errors = 0;
        checks = 0;
        wr_seen = 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        check(64'(dwait), 64'({CPUS{1'b1}}), "dwait in reset");
        check(64'(ccwait | ccinv | ccexclusive), 64'(0), "cc outputs in reset");
        check(64'(uut.l2REN | uut.l2WEN), 64'(0), "L2 enables in reset");
        forever begin
            @(negedge CLK);
            wr_seen = wr_seen | uut.l2WEN;
            if (!active) begin
                inv_seen = '0;
                wait_seen = '0;
                l2_seen = 1'b0;
            end else begin
                inv_seen = inv_seen | ccinv;
                wait_seen = wait_seen | ccwait;
                l2_seen = l2_seen | uut.l2REN | uut.l2WEN;
                if (!dwait[cur_req]) begin
                    if (cur_kind == REQ_RD || cur_kind == REQ_RDX) begin
                        check(dload[cur_req], exp_data, "dload");
                        for (int i = 0; i < CPUS; i++) begin
                            if (i != cur_req) begin
                                check(64'(ccsnoopaddr[i]), 64'(cur_addr), "ccsnoopaddr");
                            end
                        end
                    end
                    check(64'(ccexclusive[cur_req]), 64'(exp_excl), "ccexclusive");
                    check(64'(inv_seen), 64'(exp_inv), "ccinv mask");
                    if (cur_kind == REQ_RDX || cur_kind == REQ_UPD) begin
                        check(64'(wait_seen), 64'(exp_inv), "ccwait mask");
                    end
                    if (cur_kind != REQ_WB) check(64'(l2_seen), 64'(exp_l2), "L2 enable use");
                    -> txn_done;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: a bus request did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          req, blk;
        req_kind_t   kind;
        seed = 32'h06253e5b;
        active = 1'b0;
        nRST = 1'b0;
        cctrans = '0;
        dREN = '0;
        dWEN = '0;
        ccwrite = '0;
        daddr = '0;
        dstore = '0;
        for (int b = 0; b < NBLK; b++) begin
            r = $random(seed);
            // block number sits in the L2 index bits so blocks never alias
            addr_tab[b] = {r[31:9], 6'(b), 3'b000};
            ref_l2[b] = '0;
            for (int i = 0; i < CPUS; i++) begin
                mesi[i][b] = ST_I;
                cdata[i][b] = '0;
            end
        end
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);

        // ownership from L2, then dirty supplier, then readback from L2
        run_txn(1, REQ_RDX, 0);
        run_txn(2, REQ_RD, 0);
        mesi[1][0] = ST_I;
        mesi[2][0] = ST_I;
        run_txn(3, REQ_RD, 0);
        // clean supplier, upgrade, eviction and readback
        run_txn(0, REQ_RD, 0);
        run_txn(0, REQ_UPD, 0);
        run_txn(0, REQ_WB, 0);
        run_txn(2, REQ_RD, 0);

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            req = int'(r[1:0]);
            blk = int'(r[3:2]);
            case (mesi[req][blk])
                ST_M: kind = REQ_WB;
                ST_S: kind = REQ_UPD;
                ST_E: begin
                    // silent E to M on a local store, then evict
                    mesi[req][blk] = ST_M;
                    cdata[req][blk] = {$random(seed), $random(seed)};
                    kind = REQ_WB;
                end
                default: kind = r[4] ? REQ_RDX : REQ_RD;
            endcase
            run_txn(req, kind, blk);
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/coherence_pkg.sv
hdl/bus_request_arbiter.sv
hdl/bus_ctrl.sv
hdl/l2_memory.sv
hdl/coherence_bus_top.sv
test/coherence_bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module coherence_bus_tb -f all.f -o coherence_bus_sim &&
./obj_dir/coherence_bus_sim | tee /dev/stderr | grep -qxF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
